// File: src/ethRegs_defs.svh
// widths, register map indexes and MDIO control field positions, included by packages and RTL
`ifndef ETH_REGS_DEFS_SVH
`define ETH_REGS_DEFS_SVH

// ==================================================
// bus and data widths
// ==================================================
`define ETH_AXI_DATA_W 32
`define ETH_AXI_ADDR_W 32
// word-aligned address bits that pick a register
`define ETH_REG_IDX_LO 2
`define ETH_REG_IDX_HI 7
// one MDIO register
`define ETH_PHY_DATA_W 16

// ==================================================
// register map
// ==================================================
// read-only PHY shadows, same numbers as the MDIO register space
`define ETH_IDX_PHY_CTRL     6'd0
`define ETH_IDX_PHY_STAT     6'd1
`define ETH_IDX_PHY_IDENT1   6'd2
`define ETH_IDX_PHY_IDENT2   6'd3
`define ETH_IDX_PHY_ANA      6'd4
`define ETH_IDX_PHY_ANLP     6'd5
`define ETH_IDX_PHY_ANE      6'd6
// vendor-specific block
`define ETH_IDX_PHY_MODE     6'd17
`define ETH_IDX_PHY_SPECMD   6'd18
`define ETH_IDX_PHY_SYMERR   6'd26
`define ETH_IDX_PHY_INDC     6'd27
`define ETH_IDX_PHY_INTSRC   6'd29
`define ETH_IDX_PHY_INTMSK   6'd30
`define ETH_IDX_PHY_SPECCTRL 6'd31
// processor-writable user registers
`define ETH_IDX_USR_CTRL     6'd32
`define ETH_IDX_USR_WDATA    6'd33

// ==================================================
// MDIO control register fields
// ==================================================
`define ETH_CTRL_EN_BIT        0
`define ETH_CTRL_WR_BIT        1
`define ETH_CTRL_PHYADDR_LO    2
`define ETH_CTRL_PHYADDR_HI    6
`define ETH_CTRL_REGADDR_LO    7
`define ETH_CTRL_REGADDR_HI    11

`endif

// File: src/mdioRegPkg.sv
// types of the register map and the MDIO side, imported by the register file and bus package
`include "ethRegs_defs.svh"

package mdioRegPkg;

  // ==================================================
  // index and field types
  // ==================================================
  // register index, taken from address bits 7:2
  typedef logic [`ETH_REG_IDX_HI-`ETH_REG_IDX_LO:0] regIdx_t;

  // PHY and MDIO register address fields of the control word
  typedef logic [`ETH_CTRL_PHYADDR_HI-`ETH_CTRL_PHYADDR_LO:0] phyAddr_t;
  typedef logic [`ETH_CTRL_REGADDR_HI-`ETH_CTRL_REGADDR_LO:0] mdioRegAddr_t;

  // contents of one MDIO register
  typedef logic [`ETH_PHY_DATA_W-1:0] phyData_t;

  // ==================================================
  // MDIO command and status words
  // ==================================================
  // command to the management engine, unpacked from the user registers
  typedef struct packed {
    mdioRegAddr_t regAddr;
    phyAddr_t     phyAddr;
    // 1 = write, 0 = read
    logic         isWrite;
    // starts a transaction while high
    logic         enable;
    phyData_t     wrData;
  } mdioCmd_t;

  // one PHY register value coming back from the engine
  typedef struct packed {
    logic     valid;
    regIdx_t  index;
    phyData_t data;
  } mdioStatus_t;

endpackage

// File: src/axiLitePkg.sv
// bus-side types: AXI4-Lite words, request and response records and the accept FSM states
`include "ethRegs_defs.svh"

package axiLitePkg;
  import mdioRegPkg::*;

  typedef logic [`ETH_AXI_DATA_W-1:0] axiData_t;
  typedef logic [`ETH_AXI_ADDR_W-1:0] axiAddr_t;
  typedef logic [1:0]                 axiResp_t;

  // only response this block ever gives
  localparam axiResp_t RespOkay = 2'b00;

  // stage 1 -> stage 2
  typedef struct packed {
    logic     isWrite;
    regIdx_t  index;
    axiData_t wdata;
  } regReq_t;

  // stage 2 -> stage 3
  typedef struct packed {
    logic     isWrite;
    axiData_t rdata;
  } regRsp_t;

  typedef enum logic [1:0] {reqIdle, reqAccept, reqBusy} reqState_e;

endpackage

// File: src/axiReqCapture.sv
// stage 1 of the register block: accepts one AXI4-Lite write or read and issues a register request
`timescale 1ns/1ns
`include "ethRegs_defs.svh"

module axiReqCapture (
  input  logic                 AXI_Clk,
  input  logic                 rst,
  // write address and write data
  input  logic                 awvalid,
  output logic                 awready,
  input  axiLitePkg::axiAddr_t awaddr,
  input  logic                 wvalid,
  output logic                 wready,
  input  axiLitePkg::axiData_t wdata,
  // read address
  input  logic                 arvalid,
  output logic                 arready,
  input  axiLitePkg::axiAddr_t araddr,
  // response taken by the master, from stage 3
  input  logic                 rspDone,
  output axiLitePkg::regReq_t  regReq,
  output logic                 reqValid
);
  import axiLitePkg::*;

  reqState_e state;
  logic      wrWins;

  // write needs both channels; beats a read in the same cycle
  assign wrWins = awvalid && wvalid;

  // ==================================================
  // accept FSM
  // ==================================================
  always_ff @(posedge AXI_Clk) begin
    if (rst) begin
      state    <= reqIdle;
      awready  <= 1'b0;
      wready   <= 1'b0;
      arready  <= 1'b0;
      reqValid <= 1'b0;
    end else begin
      // readies and reqValid only pulse
      awready  <= 1'b0;
      wready   <= 1'b0;
      arready  <= 1'b0;
      reqValid <= 1'b0;
      case (state)
        reqIdle: begin
          if (wrWins) begin
            awready <= 1'b1;
            wready  <= 1'b1;
            state   <= reqAccept;
          end else if (arvalid) begin
            arready <= 1'b1;
            state   <= reqAccept;
          end
        end
        reqAccept: begin
          // bus handshake completes on this edge
          reqValid <= 1'b1;
          state    <= reqBusy;
        end
        reqBusy: begin
          // hold off new requests until the response is gone
          if (rspDone) begin
            state <= reqIdle;
          end
        end
        default: begin
          state <= reqIdle;
        end
      endcase
    end
  end

  // request payload
  // sampled in idle, master keeps it stable until the handshake
  always_ff @(posedge AXI_Clk) begin
    if (state == reqIdle) begin
      regReq.isWrite <= wrWins;
      regReq.index   <= wrWins ? awaddr[`ETH_REG_IDX_HI:`ETH_REG_IDX_LO]
                               : araddr[`ETH_REG_IDX_HI:`ETH_REG_IDX_LO];
      regReq.wdata   <= wdata;
    end
  end

  // ready pulses only while the FSM sits in accept
  assert property (@(posedge AXI_Clk) disable iff (rst)
    (awready || arready) |-> state == reqAccept);

  // address and data channels of a write are taken together
  assert property (@(posedge AXI_Clk) disable iff (rst) awready == wready);

endmodule

// File: src/regFileAccess.sv
// stage 2 of the register block: user registers, PHY shadows and read mux, one response per request
`timescale 1ns/1ns
`include "ethRegs_defs.svh"

module regFileAccess (
  input  logic                    AXI_Clk,
  input  logic                    rst,
  input  axiLitePkg::regReq_t     regReq,
  input  logic                    reqValid,
  input  mdioRegPkg::mdioStatus_t mdioStatus,
  output axiLitePkg::regRsp_t     regRsp,
  output logic                    rspValid,
  output mdioRegPkg::mdioCmd_t    mdioCmd
);
  import axiLitePkg::*;
  import mdioRegPkg::*;

  localparam int         NumPhyRegs = 14;
  // slot code for anything that is not a PHY shadow
  localparam logic [3:0] NoSlot     = 4'hF;

  axiData_t   usrCtrl;
  axiData_t   usrWdata;
  phyData_t   phyShadow [NumPhyRegs];
  logic [3:0] statusSlot;
  logic [3:0] readSlot;
  axiData_t   readData;

  // sparse PHY index -> dense shadow slot
  function automatic logic [3:0] phySlot(input regIdx_t idx);
    case (idx)
      `ETH_IDX_PHY_CTRL:     phySlot = 4'd0;
      `ETH_IDX_PHY_STAT:     phySlot = 4'd1;
      `ETH_IDX_PHY_IDENT1:   phySlot = 4'd2;
      `ETH_IDX_PHY_IDENT2:   phySlot = 4'd3;
      `ETH_IDX_PHY_ANA:      phySlot = 4'd4;
      `ETH_IDX_PHY_ANLP:     phySlot = 4'd5;
      `ETH_IDX_PHY_ANE:      phySlot = 4'd6;
      `ETH_IDX_PHY_MODE:     phySlot = 4'd7;
      `ETH_IDX_PHY_SPECMD:   phySlot = 4'd8;
      `ETH_IDX_PHY_SYMERR:   phySlot = 4'd9;
      `ETH_IDX_PHY_INDC:     phySlot = 4'd10;
      `ETH_IDX_PHY_INTSRC:   phySlot = 4'd11;
      `ETH_IDX_PHY_INTMSK:   phySlot = 4'd12;
      `ETH_IDX_PHY_SPECCTRL: phySlot = 4'd13;
      default:               phySlot = NoSlot;
    endcase
  endfunction

  assign statusSlot = phySlot(mdioStatus.index);
  assign readSlot   = phySlot(regReq.index);

  // ==================================================
  // PHY shadows, loaded by the management engine only
  // ==================================================
  always_ff @(posedge AXI_Clk) begin
    if (rst) begin
      for (int i = 0; i < NumPhyRegs; i++) begin
        phyShadow[i] <= '0;
      end
    end else if (mdioStatus.valid && statusSlot != NoSlot) begin
      // each shadow takes only its own index
      phyShadow[statusSlot] <= mdioStatus.data;
    end
  end

  // ==================================================
  // user registers, bus writes elsewhere are dropped
  // ==================================================
  always_ff @(posedge AXI_Clk) begin
    if (rst) begin
      usrCtrl  <= '0;
      usrWdata <= '0;
    end else if (reqValid && regReq.isWrite) begin
      if (regReq.index == `ETH_IDX_USR_CTRL) begin
        usrCtrl <= regReq.wdata;
      end
      if (regReq.index == `ETH_IDX_USR_WDATA) begin
        usrWdata <= regReq.wdata;
      end
    end
  end

  // read mux, unmapped reads as zero
  always_comb begin
    if (readSlot != NoSlot) begin
      readData = {{(`ETH_AXI_DATA_W-`ETH_PHY_DATA_W){1'b0}}, phyShadow[readSlot]};
    end else if (regReq.index == `ETH_IDX_USR_CTRL) begin
      readData = usrCtrl;
    end else if (regReq.index == `ETH_IDX_USR_WDATA) begin
      readData = usrWdata;
    end else begin
      readData = '0;
    end
  end

  // one response per request, a cycle later
  always_ff @(posedge AXI_Clk) begin
    if (rst) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= reqValid;
    end
  end

  always_ff @(posedge AXI_Clk) begin
    if (reqValid) begin
      regRsp.isWrite <= regReq.isWrite;
      regRsp.rdata   <= regReq.isWrite ? '0 : readData;
    end
  end

  // MDIO command fields straight from the user registers
  assign mdioCmd.regAddr = usrCtrl[`ETH_CTRL_REGADDR_HI:`ETH_CTRL_REGADDR_LO];
  assign mdioCmd.phyAddr = usrCtrl[`ETH_CTRL_PHYADDR_HI:`ETH_CTRL_PHYADDR_LO];
  assign mdioCmd.isWrite = usrCtrl[`ETH_CTRL_WR_BIT];
  assign mdioCmd.enable  = usrCtrl[`ETH_CTRL_EN_BIT];
  assign mdioCmd.wrData  = usrWdata[`ETH_PHY_DATA_W-1:0];

  // no request is ever lost or duplicated on the way to stage 3
  assert property (@(posedge AXI_Clk) disable iff (rst) rspValid == $past(reqValid));

endmodule

// File: src/axiRespDrive.sv
// stage 3 of the register block: drives the AXI4-Lite B or R channel and holds it until accepted
`timescale 1ns/1ns

module axiRespDrive (
  input  logic                 AXI_Clk,
  input  logic                 rst,
  input  axiLitePkg::regRsp_t  regRsp,
  input  logic                 rspValid,
  // write response
  output logic                 bvalid,
  input  logic                 bready,
  output axiLitePkg::axiResp_t bresp,
  // read data
  output logic                 rvalid,
  input  logic                 rready,
  output axiLitePkg::axiResp_t rresp,
  output axiLitePkg::axiData_t rdata,
  // frees stage 1
  output logic                 rspDone
);
  import axiLitePkg::*;

  logic bDone;
  logic rDone;

  assign bDone = bvalid && bready;
  assign rDone = rvalid && rready;

  // ==================================================
  // valid flags, held under back-pressure
  // ==================================================
  always_ff @(posedge AXI_Clk) begin
    if (rst) begin
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
      rspDone <= 1'b0;
    end else begin
      rspDone <= bDone || rDone;
      if (rspValid && regRsp.isWrite) begin
        bvalid <= 1'b1;
      end else if (bDone) begin
        bvalid <= 1'b0;
      end
      if (rspValid && !regRsp.isWrite) begin
        rvalid <= 1'b1;
      end else if (rDone) begin
        rvalid <= 1'b0;
      end
    end
  end

  // read word, frozen while rvalid waits
  always_ff @(posedge AXI_Clk) begin
    if (rspValid && !regRsp.isWrite) begin
      rdata <= regRsp.rdata;
    end
  end

  // no error cases in this map
  assign bresp = RespOkay;
  assign rresp = RespOkay;

  // single transaction in flight
  assert property (@(posedge AXI_Clk) disable iff (rst) !(bvalid && rvalid));

  assert property (@(posedge AXI_Clk) disable iff (rst)
    (rvalid && !rready) |=> $stable(rdata));

endmodule

// File: src/ethRegsTop.sv
// top of the Ethernet PHY management register block: AXI4-Lite slave, MDIO command and status
`timescale 1ns/1ns

module ethRegsTop (
  input  logic                    AXI_Clk,
  input  logic                    rst,
  // AXI4-Lite write side
  input  logic                    awvalid,
  output logic                    awready,
  input  axiLitePkg::axiAddr_t    awaddr,
  input  logic                    wvalid,
  output logic                    wready,
  input  axiLitePkg::axiData_t    wdata,
  output logic                    bvalid,
  input  logic                    bready,
  output axiLitePkg::axiResp_t    bresp,
  // AXI4-Lite read side
  input  logic                    arvalid,
  output logic                    arready,
  input  axiLitePkg::axiAddr_t    araddr,
  output logic                    rvalid,
  input  logic                    rready,
  output axiLitePkg::axiData_t    rdata,
  output axiLitePkg::axiResp_t    rresp,
  // management engine
  output mdioRegPkg::mdioCmd_t    mdioCmd,
  input  mdioRegPkg::mdioStatus_t mdioStatus
);
  import axiLitePkg::*;

  // stage links
  regReq_t regReq;
  logic    reqValid;
  regRsp_t regRsp;
  logic    rspValid;
  logic    rspDone;

  // ==================================================
  // capture -> access -> response
  // ==================================================
  axiReqCapture i_reqCapture (
    .AXI_Clk  (AXI_Clk),
    .rst      (rst),
    .awvalid  (awvalid),
    .awready  (awready),
    .awaddr   (awaddr),
    .wvalid   (wvalid),
    .wready   (wready),
    .wdata    (wdata),
    .arvalid  (arvalid),
    .arready  (arready),
    .araddr   (araddr),
    .rspDone  (rspDone),
    .regReq   (regReq),
    .reqValid (reqValid)
  );

  regFileAccess i_regFile (
    .AXI_Clk    (AXI_Clk),
    .rst        (rst),
    .regReq     (regReq),
    .reqValid   (reqValid),
    .mdioStatus (mdioStatus),
    .regRsp     (regRsp),
    .rspValid   (rspValid),
    .mdioCmd    (mdioCmd)
  );

  axiRespDrive i_respDrive (
    .AXI_Clk  (AXI_Clk),
    .rst      (rst),
    .regRsp   (regRsp),
    .rspValid (rspValid),
    .bvalid   (bvalid),
    .bready   (bready),
    .bresp    (bresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .rresp    (rresp),
    .rdata    (rdata),
    .rspDone  (rspDone)
  );

endmodule

// File: verification/ethRegsTb.sv
// testbench that runs a table of bus and status steps against a register model of the block
`timescale 1ns/1ns
`include "ethRegs_defs.svh"

module ethRegsTb;
  import axiLitePkg::*;
  import mdioRegPkg::*;

  localparam axiResp_t Okay       = 2'b00;
  localparam int       SelAwReady = 0;
  localparam int       SelArReady = 1;
  localparam int       SelBvalid  = 2;
  localparam int       SelRvalid  = 3;

  typedef enum logic [1:0] {opWrite, opRead, opInject, opBoth} stepOp_e;

  // one table row with expected values from the model
  typedef struct packed {
    stepOp_e  op;
    regIdx_t  idx;
    axiData_t data;
    axiData_t expData;
    mdioCmd_t expCmd;
  } step_t;

  logic        AXI_Clk;
  logic        rst;
  logic        awvalid, awready, wvalid, wready, arvalid, arready;
  logic        bvalid, bready, rvalid, rready;
  axiAddr_t    awaddr, araddr;
  axiData_t    wdata, rdata;
  axiResp_t    bresp, rresp;
  mdioCmd_t    mdioCmd;
  mdioStatus_t mdioStatus;

  step_t    steps[$];
  axiData_t modelReg [64];
  integer   seed;
  int       errors;
  int       timeouts;
  logic     aborted;

  ethRegsTop i_dut (.*);

  initial begin
    AXI_Clk = 1'b0;
    forever #2 AXI_Clk = ~AXI_Clk;
  end

  // ==================================================
  // compare tasks
  // ==================================================
  task automatic checkAxiData(input string name, input axiData_t actual, input axiData_t expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic checkResp(input string name, input axiResp_t actual, input axiResp_t expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic checkMdioCmd(input mdioCmd_t actual, input mdioCmd_t expected);
    if (actual !== expected) begin
      $display("[FAIL] mdioCmd: got 0x%07h, expected 0x%07h", actual, expected);
      errors++;
    end
  endtask

  task automatic checkFlag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      errors++;
    end
  endtask

  // ==================================================
  // register model
  // ==================================================
  function automatic logic isPhyIdx(input regIdx_t idx);
    return idx inside {`ETH_IDX_PHY_CTRL, `ETH_IDX_PHY_STAT, `ETH_IDX_PHY_IDENT1,
                       `ETH_IDX_PHY_IDENT2, `ETH_IDX_PHY_ANA, `ETH_IDX_PHY_ANLP,
                       `ETH_IDX_PHY_ANE, `ETH_IDX_PHY_MODE, `ETH_IDX_PHY_SPECMD,
                       `ETH_IDX_PHY_SYMERR, `ETH_IDX_PHY_INDC, `ETH_IDX_PHY_INTSRC,
                       `ETH_IDX_PHY_INTMSK, `ETH_IDX_PHY_SPECCTRL};
  endfunction

  // command fields as the control word lays them out
  function automatic mdioCmd_t modelCmd();
    mdioCmd_t c;
    c.regAddr = modelReg[`ETH_IDX_USR_CTRL][`ETH_CTRL_REGADDR_HI:`ETH_CTRL_REGADDR_LO];
    c.phyAddr = modelReg[`ETH_IDX_USR_CTRL][`ETH_CTRL_PHYADDR_HI:`ETH_CTRL_PHYADDR_LO];
    c.isWrite = modelReg[`ETH_IDX_USR_CTRL][`ETH_CTRL_WR_BIT];
    c.enable  = modelReg[`ETH_IDX_USR_CTRL][`ETH_CTRL_EN_BIT];
    c.wrData  = modelReg[`ETH_IDX_USR_WDATA][`ETH_PHY_DATA_W-1:0];
    return c;
  endfunction

  // applies one step to the model and records what the DUT must show
  task automatic addStep(input stepOp_e op, input regIdx_t idx, input axiData_t data);
    step_t s;
    if ((op == opWrite || op == opBoth) &&
        (idx == `ETH_IDX_USR_CTRL || idx == `ETH_IDX_USR_WDATA)) begin
      modelReg[idx] = data;
    end
    if (op == opInject && isPhyIdx(idx)) begin
      // 16-bit PHY word, upper half reads as zero
      modelReg[idx] = data & 32'h0000_FFFF;
    end
    s.op      = op;
    s.idx     = idx;
    s.data    = data;
    s.expData = modelReg[idx];
    s.expCmd  = modelCmd();
    steps.push_back(s);
  endtask

  task automatic buildTable();
    // user registers start at zero
    addStep(opRead, `ETH_IDX_USR_CTRL, '0);
    addStep(opRead, `ETH_IDX_USR_WDATA, '0);
    // en=1 wr=1 phy=0x0B reg=0x1D with junk in the upper half
    addStep(opWrite, `ETH_IDX_USR_CTRL, 32'hA5A5_0EAF);
    addStep(opWrite, `ETH_IDX_USR_WDATA, 32'hC0DE_BEEF);
    addStep(opRead, `ETH_IDX_USR_CTRL, '0);
    addStep(opRead, `ETH_IDX_USR_WDATA, '0);
    // distinct data per PHY index
    for (int i = 0; i < 64; i++) begin
      if (isPhyIdx(regIdx_t'(i))) begin
        addStep(opInject, regIdx_t'(i), 32'h5A00 ^ (i * 32'h0123));
      end
    end
    // status on indexes that are no shadow
    addStep(opInject, 6'd7, 32'hFFFF);
    addStep(opInject, `ETH_IDX_USR_CTRL, 32'hFFFF);
    addStep(opInject, 6'd40, 32'hFFFF);
    for (int i = 0; i < 64; i++) begin
      addStep(opRead, regIdx_t'(i), '0);
    end
    // bus writes that must be dropped
    addStep(opWrite, `ETH_IDX_PHY_IDENT1, 32'hFFFF_FFFF);
    addStep(opRead, `ETH_IDX_PHY_IDENT1, '0);
    addStep(opWrite, 6'd40, 32'h1234_5678);
    addStep(opRead, 6'd40, '0);
    // write and read raised together
    addStep(opBoth, `ETH_IDX_USR_WDATA, 32'h0BAD_F00D);
    addStep(opWrite, `ETH_IDX_USR_CTRL, 32'h0000_0000);
    addStep(opRead, `ETH_IDX_USR_CTRL, '0);
  endtask

  // ==================================================
  // bus drivers
  // ==================================================
  function automatic logic sigValue(input int sel);
    case (sel)
      SelAwReady: return awready;
      SelArReady: return arready;
      SelBvalid:  return bvalid;
      default:    return rvalid;
    endcase
  endfunction

  // polls on falling edges and gives up after 64 cycles
  task automatic waitHigh(input int sel, input string name);
    int n;
    n = 0;
    while (!sigValue(sel) && !aborted) begin
      @(negedge AXI_Clk);
      n++;
      if (n >= 64 && !sigValue(sel)) begin
        $display("timeout: %s never went high within 64 cycles", name);
        timeouts++;
        aborted = 1'b1;
      end
    end
  endtask

  task automatic takeWriteResp();
    int stall;
    waitHigh(SelBvalid, "bvalid");
    if (aborted) return;
    // at least one cycle of back-pressure
    stall = 1 + $unsigned($random(seed)) % 6;
    repeat (stall) begin
      @(negedge AXI_Clk);
      checkFlag("bvalid", bvalid, 1'b1);
      checkFlag("awready", awready, 1'b0);
      checkFlag("arready", arready, 1'b0);
    end
    checkResp("bresp", bresp, Okay);
    bready = 1'b1;
    @(negedge AXI_Clk);
    bready = 1'b0;
    checkFlag("bvalid", bvalid, 1'b0);
  endtask

  task automatic busWrite(input regIdx_t idx, input axiData_t data, input logic alsoRead);
    awaddr  = axiAddr_t'(idx) << `ETH_REG_IDX_LO;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // same address on the read channel that must wait its turn
    if (alsoRead) begin
      araddr  = axiAddr_t'(idx) << `ETH_REG_IDX_LO;
      arvalid = 1'b1;
    end
    waitHigh(SelAwReady, "awready");
    if (aborted) return;
    checkFlag("wready", wready, 1'b1);
    checkFlag("arready", arready, 1'b0);
    @(negedge AXI_Clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    takeWriteResp();
  endtask

  task automatic busRead(input regIdx_t idx, input axiData_t expected);
    axiData_t held;
    int       stall;
    araddr  = axiAddr_t'(idx) << `ETH_REG_IDX_LO;
    arvalid = 1'b1;
    waitHigh(SelArReady, "arready");
    if (aborted) return;
    checkFlag("awready", awready, 1'b0);
    @(negedge AXI_Clk);
    arvalid = 1'b0;
    waitHigh(SelRvalid, "rvalid");
    if (aborted) return;
    held  = rdata;
    stall = 1 + $unsigned($random(seed)) % 6;
    // read word must not move while the master stalls
    repeat (stall) begin
      @(negedge AXI_Clk);
      checkFlag("rvalid", rvalid, 1'b1);
      checkAxiData("rdata", rdata, held);
      checkFlag("awready", awready, 1'b0);
      checkFlag("arready", arready, 1'b0);
    end
    checkAxiData("rdata", held, expected);
    checkResp("rresp", rresp, Okay);
    rready = 1'b1;
    @(negedge AXI_Clk);
    rready = 1'b0;
    checkFlag("rvalid", rvalid, 1'b0);
  endtask

  task automatic injectStatus(input regIdx_t idx, input phyData_t phyWord);
    mdioStatus = '{valid: 1'b1, index: idx, data: phyWord};
    @(negedge AXI_Clk);
    mdioStatus.valid = 1'b0;
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    seed       = 38945;
    errors     = 0;
    timeouts   = 0;
    aborted    = 1'b0;
    rst        = 1'b1;
    awvalid    = 1'b0;
    wvalid     = 1'b0;
    arvalid    = 1'b0;
    bready     = 1'b0;
    rready     = 1'b0;
    awaddr     = '0;
    araddr     = '0;
    wdata      = '0;
    mdioStatus = '0;
    for (int i = 0; i < 64; i++) begin
      modelReg[i] = '0;
    end
    buildTable();
    repeat (16) @(posedge AXI_Clk);
    @(negedge AXI_Clk);
    rst = 1'b0;
    @(negedge AXI_Clk);
    // idle outputs out of reset
    checkFlag("awready", awready, 1'b0);
    checkFlag("wready", wready, 1'b0);
    checkFlag("arready", arready, 1'b0);
    checkFlag("bvalid", bvalid, 1'b0);
    checkFlag("rvalid", rvalid, 1'b0);
    checkResp("bresp", bresp, Okay);
    checkResp("rresp", rresp, Okay);
    checkMdioCmd(mdioCmd, '0);
    for (int k = 0; k < steps.size() && !aborted; k++) begin
      case (steps[k].op)
        opWrite:  busWrite(steps[k].idx, steps[k].data, 1'b0);
        opRead:   busRead(steps[k].idx, steps[k].expData);
        opInject: injectStatus(steps[k].idx, steps[k].data[`ETH_PHY_DATA_W-1:0]);
        default: begin
          busWrite(steps[k].idx, steps[k].data, 1'b1);
          if (!aborted) busRead(steps[k].idx, steps[k].expData);
        end
      endcase
      if (!aborted) checkMdioCmd(mdioCmd, steps[k].expCmd);
    end
    $display("value errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+src
src/mdioRegPkg.sv
src/axiLitePkg.sv
src/axiReqCapture.sv
src/regFileAccess.sv
src/axiRespDrive.sv
src/ethRegsTop.sv
verification/ethRegsTb.sv

// File: Makefile
SIM := obj_dir/ethRegsSim

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module ethRegsTb

$(SIM): all.f src/*.sv src/*.svh verification/*.sv
	verilator --binary --timing --assert -f all.f --top-module ethRegsTb -o ethRegsSim

sim: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
